//--- l2_axi_bus_interface.f
source/l2_cache_pkg.sv
source/sync_fifo.sv
source/l2_pending_miss_cam.sv
source/l2_axi_bus_interface.sv
test/l2_axi_bus_interface_assertions.sv
test/l2_axi_bus_interface_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = l2_axi_bus_interface_tb
FILELIST = l2_axi_bus_interface.f
OBJ_DIR = obj_dir

SOURCES = $(shell grep -v '^+' $(FILELIST))
BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- test/l2_axi_bus_interface_tb.sv
`default_nettype none
`timescale 1ns/100ps

module l2_axi_bus_interface_tb;
	localparam int queue_depth = 8;
	localparam int stall_level = queue_depth - l2_cache_pkg::l2req_latency;
	// Roughly 150 requests, each at most about 25 cycles under random back-pressure
	localparam int max_cycles = 4000;

	typedef struct packed {
		l2_cache_pkg::l2req_packet_t request;
		logic collided;
		logic reads;
	} expected_response_t;

	typedef struct packed {
		l2_cache_pkg::cache_line_index_t line;
		l2_cache_pkg::cache_line_data_t data;
	} expected_writeback_t;

	logic clk;
	logic reset;
	l2_cache_pkg::axi_master_t axi_out;
	l2_cache_pkg::axi_slave_t axi_in;
	l2_cache_pkg::l2req_packet_t l2bi_request;
	l2_cache_pkg::cache_line_data_t l2bi_data_from_memory;
	logic l2bi_stall;
	logic l2bi_ready;
	logic l2bi_collided_miss;
	logic l2r_needs_writeback;
	l2_cache_pkg::l2_tag_t l2r_writeback_tag;
	l2_cache_pkg::cache_line_data_t l2r_data;
	logic l2r_is_l2_fill;
	logic l2r_cache_hit;
	l2_cache_pkg::l2req_packet_t l2r_request;
	logic perf_l2_writeback;

	// Reference model state
	expected_response_t response_queue[$];
	expected_writeback_t writeback_queue[$];
	l2_cache_pkg::cache_line_index_t read_queue[$];
	l2_cache_pkg::cache_line_index_t pending_lines[$];
	l2_cache_pkg::cache_line_index_t fill_lines[$];
	l2_cache_pkg::cache_line_index_t memory_reads[$];
	int write_beat;
	int read_beat;
	int bvalid_pending;
	int checks;
	int errors;
	int cycles;
	logic hold_arready;

	l2_axi_bus_interface #(.queue_depth(queue_depth)) uut(.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Word k of line L as system memory returns it
	function automatic l2_cache_pkg::axi_data_t memory_word(
		l2_cache_pkg::cache_line_index_t line, int beat);
		return l2_cache_pkg::axi_data_t'({line, 4'(beat)}) * 32'h9e3779b1 + 32'(beat);
	endfunction

	// Beat 0 ends up in the top word of the line
	function automatic l2_cache_pkg::cache_line_data_t memory_line(
		l2_cache_pkg::cache_line_index_t line);
		l2_cache_pkg::cache_line_data_t data;
		for (int k = 0; k < 4; k++)
			data[(3 - k) * 32+:32] = memory_word(line, k);
		return data;
	endfunction

	function automatic l2_cache_pkg::l2req_packet_t make_packet(
		l2_cache_pkg::l2req_type_t kind, l2_cache_pkg::cache_line_index_t line,
		l2_cache_pkg::store_mask_t mask);
		l2_cache_pkg::l2req_packet_t packet;
		packet.valid = 1'b1;
		packet.packet_type = kind;
		packet.address = '{tag: line.tag, set_idx: line.set_idx, offset: 4'($urandom)};
		packet.store_mask = mask;
		packet.data = {$urandom, $urandom, $urandom, $urandom};
		return packet;
	endfunction

	function automatic l2_cache_pkg::cache_line_index_t random_line(int pool);
		return '{tag: l2_cache_pkg::l2_tag_t'($urandom % pool),
			set_idx: l2_cache_pkg::set_index_t'($urandom % pool)};
	endfunction

	function automatic logic line_pending(l2_cache_pkg::cache_line_index_t line);
		foreach (pending_lines[i])
			if (pending_lines[i] == line)
				return 1'b1;
		return 1'b0;
	endfunction

	task automatic expect_equal(string name, logic [191:0] expected, logic [191:0] actual);
		checks++;
		assert (actual == expected)
		else
		begin
			errors++;
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic report_failure(string what);
		errors++;
		$display("%s", what);
	endtask

	// Present one request from l2r for a cycle and record what it should cause
	task automatic send(l2_cache_pkg::l2req_packet_t packet, logic fill, logic hit, logic dirty);
		l2_cache_pkg::cache_line_index_t line;
		expected_response_t response;
		logic wb_enqueue;
		logic load_enqueue;
		line = '{tag: packet.address.tag, set_idx: packet.address.set_idx};
		while (l2bi_stall)
			@(negedge clk);
		l2r_request = packet;
		l2r_is_l2_fill = fill;
		l2r_cache_hit = hit;
		l2r_needs_writeback = dirty;
		l2r_writeback_tag = l2_cache_pkg::l2_tag_t'($urandom);
		l2r_data = {$urandom, $urandom, $urandom, $urandom};
		wb_enqueue = dirty && ((packet.packet_type == l2_cache_pkg::l2req_flush && hit) || fill);
		load_enqueue = !hit && !fill && packet.packet_type != l2_cache_pkg::l2req_flush;
		#1;
		expect_equal("perf_l2_writeback", wb_enqueue, perf_l2_writeback);
		@(posedge clk);
		if (wb_enqueue)
			writeback_queue.push_back('{line: '{tag: l2r_writeback_tag,
				set_idx: packet.address.set_idx}, data: l2r_data});
		if (load_enqueue)
		begin
			response.request = packet;
			response.collided = line_pending(line);
			response.reads = !response.collided
				&& !(packet.packet_type == l2_cache_pkg::l2req_store && packet.store_mask == '1);
			response_queue.push_back(response);
			if (response.reads)
				read_queue.push_back(line);
			if (!response.collided)
				pending_lines.push_back(line);
		end
		// A fill makes the line resident, so later misses read again
		if (fill)
		begin
			for (int i = pending_lines.size() - 1; i >= 0; i--)
				if (pending_lines[i] == line)
					pending_lines.delete(i);
		end
		@(negedge clk);
		l2r_request.valid = 1'b0;
		l2r_is_l2_fill = 1'b0;
		l2r_needs_writeback = 1'b0;
	endtask

	task automatic drain();
		while (response_queue.size() != 0 || writeback_queue.size() != 0)
			@(negedge clk);
	endtask

	// The arbiter writes every fetched line back through l2r as a fill
	task automatic replay_fills(logic dirty);
		l2_cache_pkg::cache_line_index_t line;
		while (fill_lines.size() != 0)
		begin
			line = fill_lines.pop_front();
			send(make_packet(l2_cache_pkg::l2req_load, line, '0), 1'b1, 1'b0, dirty);
		end
		drain();
	endtask

	// Memory model and scoreboard, sampled on the rising edge
	always @(posedge clk)
	begin
		expected_response_t response;
		if (!reset)
		begin
			if (axi_out.awvalid && axi_in.awready)
			begin
				write_beat = 0;
				if (writeback_queue.size() == 0)
					report_failure("Write burst started with no writeback queued");
				else
					expect_equal("awaddr", {writeback_queue[0].line, 4'h0}, axi_out.awaddr);
			end
			if (axi_out.wvalid && axi_in.wready && writeback_queue.size() != 0)
			begin
				expect_equal("wdata", writeback_queue[0].data[(3 - write_beat) * 32+:32],
					axi_out.wdata);
				expect_equal("wlast", write_beat == 3, axi_out.wlast);
				if (write_beat == 3)
				begin
					void'(writeback_queue.pop_front());
					bvalid_pending++;
				end
				write_beat++;
			end
			if (axi_out.arvalid && axi_in.arready)
			begin
				if (read_queue.size() == 0)
					report_failure("Read burst started although no read was expected");
				else
				begin
					expect_equal("araddr", {read_queue[0], 4'h0}, axi_out.araddr);
					memory_reads.push_back(read_queue.pop_front());
				end
			end
			if (axi_out.rready && axi_in.rvalid)
			begin
				read_beat++;
				if (read_beat == 4)
				begin
					read_beat = 0;
					void'(memory_reads.pop_front());
				end
			end
			if (l2bi_ready)
			begin
				if (response_queue.size() == 0)
					report_failure("l2bi_ready pulsed with no request outstanding");
				else
				begin
					response = response_queue.pop_front();
					expect_equal("l2bi_request", response.request, l2bi_request);
					expect_equal("l2bi_collided_miss", response.collided, l2bi_collided_miss);
					if (response.reads)
						expect_equal("l2bi_data_from_memory",
							memory_line(response.request.address[31:4]), l2bi_data_from_memory);
					if (!response.collided)
						fill_lines.push_back(response.request.address[31:4]);
				end
			end
		end
	end

	// Memory handshakes with random delays, and the per-cycle stall check
	always @(negedge clk)
	begin
		if (reset)
			axi_in = '0;
		else
		begin
			axi_in.awready = 1'($urandom);
			axi_in.wready = 1'($urandom);
			axi_in.arready = !hold_arready && 1'($urandom);
			axi_in.rvalid = memory_reads.size() != 0 && 1'($urandom);
			axi_in.rdata = memory_reads.size() != 0 ? memory_word(memory_reads[0], read_beat) : '0;
			axi_in.bvalid = bvalid_pending > 0;
			if (bvalid_pending > 0)
				bvalid_pending--;
			expect_equal("l2bi_stall", response_queue.size() >= stall_level
				|| writeback_queue.size() >= stall_level, l2bi_stall);
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= max_cycles)
		begin
			$display("Timeout after %0d cycles, the bus interface stopped responding", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial
	begin
		l2_cache_pkg::cache_line_index_t line;
		l2_cache_pkg::l2req_type_t miss_kinds[4];
		miss_kinds = '{l2_cache_pkg::l2req_load, l2_cache_pkg::l2req_store,
			l2_cache_pkg::l2req_load_sync, l2_cache_pkg::l2req_store_sync};
		void'($urandom(32'h155a));
		checks = 0;
		errors = 0;
		cycles = 0;
		write_beat = 0;
		read_beat = 0;
		bvalid_pending = 0;
		hold_arready = 1'b0;
		axi_in = '0;
		l2r_request = '0;
		l2r_needs_writeback = 1'b0;
		l2r_writeback_tag = '0;
		l2r_data = '0;
		l2r_is_l2_fill = 1'b0;
		l2r_cache_hit = 1'b0;
		reset = 1'b1;
		repeat (4)
			@(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Plain load miss, then its fill with a dirty victim
		send(make_packet(l2_cache_pkg::l2req_load, random_line(64), '0), 1'b0, 1'b0, 1'b0);
		drain();
		replay_fills(1'b1);

		// Flush that hits a dirty line
		send(make_packet(l2_cache_pkg::l2req_flush, random_line(64), '0), 1'b0, 1'b1, 1'b1);
		drain();

		// Second miss to a line in flight, then a fresh miss once it is filled
		line = random_line(64);
		send(make_packet(l2_cache_pkg::l2req_load, line, '0), 1'b0, 1'b0, 1'b0);
		send(make_packet(l2_cache_pkg::l2req_store, line, 16'h00ff), 1'b0, 1'b0, 1'b0);
		drain();
		replay_fills(1'b0);
		send(make_packet(l2_cache_pkg::l2req_load, line, '0), 1'b0, 1'b0, 1'b0);
		drain();
		replay_fills(1'b0);

		// Store covering the whole line
		send(make_packet(l2_cache_pkg::l2req_store, random_line(64), '1), 1'b0, 1'b0, 1'b0);
		drain();
		replay_fills(1'b0);

		// Back up the load queue behind a blocked read address channel
		hold_arready = 1'b1;
		for (int i = 0; i < stall_level; i++)
			send(make_packet(l2_cache_pkg::l2req_load, '{tag: l2_cache_pkg::l2_tag_t'(i + 5),
				set_idx: l2_cache_pkg::set_index_t'(i)}, '0), 1'b0, 1'b0, 1'b0);
		repeat (3)
			@(negedge clk);
		expect_equal("stall with full load queue", 1'b1, l2bi_stall);
		hold_arready = 1'b0;
		drain();
		replay_fills(1'b0);

		// Random mix over a small set of lines so that collisions happen
		repeat (80)
		begin
			if (pending_lines.size() >= 6)
			begin
				drain();
				replay_fills(1'($urandom));
			end
			else
			begin
				case ($urandom % 6)
					0, 1, 2: send(make_packet(miss_kinds[$urandom % 4], random_line(4),
						($urandom % 4 == 0) ? '1 : 16'($urandom)), 1'b0, 1'b0, 1'b0);
					3: send(make_packet(l2_cache_pkg::l2req_flush, random_line(4), '0),
						1'b0, 1'b1, 1'b1);
					4:
					begin
						if (fill_lines.size() != 0)
							send(make_packet(l2_cache_pkg::l2req_load, fill_lines.pop_front(), '0),
								1'b1, 1'b0, 1'($urandom));
					end
					default: @(negedge clk);
				endcase
			end
		end
		drain();
		replay_fills(1'b1);

		// Protocol properties that failed in the bound checker count as errors too
		errors += uut.protocol_checks.failure_count;
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end
endmodule

`default_nettype wire

//--- test/l2_axi_bus_interface_assertions.sv
`default_nettype none
`timescale 1ns/100ps

// Bus protocol and ordering properties, bound into the bus interface
module l2_axi_bus_interface_assertions
	(input logic clk,
	input logic reset,
	input l2_cache_pkg::axi_master_t axi_out,
	input l2_cache_pkg::axi_slave_t axi_in,
	input logic l2bi_stall,
	input logic perf_l2_writeback,
	input logic writeback_queue_empty);

	// Number of property violations seen so far
	int failure_count = 0;

	// A write address waiting for awready keeps its valid and address
	aw_stable: assert property (@(posedge clk) disable iff (reset)
		axi_out.awvalid && !axi_in.awready |=> axi_out.awvalid && $stable(axi_out.awaddr))
		else
		begin
			failure_count++;
			$error("write address changed before awready");
		end

	// Write data and wlast hold until wready
	w_stable: assert property (@(posedge clk) disable iff (reset)
		axi_out.wvalid && !axi_in.wready
		|=> axi_out.wvalid && $stable(axi_out.wdata) && $stable(axi_out.wlast))
		else
		begin
			failure_count++;
			$error("write data changed before wready");
		end

	ar_stable: assert property (@(posedge clk) disable iff (reset)
		axi_out.arvalid && !axi_in.arready |=> axi_out.arvalid && $stable(axi_out.araddr))
		else
		begin
			failure_count++;
			$error("read address changed before arready");
		end

	// A read may only leave idle once no writeback is queued
	writebacks_first: assert property (@(posedge clk) disable iff (reset)
		$rose(axi_out.arvalid) |-> $past(writeback_queue_empty))
		else
		begin
			failure_count++;
			$error("read address issued while a writeback was queued");
		end

	// Everything the block drives stays quiet while in reset
	reset_quiet: assert property (@(posedge clk)
		reset |-> !(axi_out.awvalid || axi_out.wvalid || axi_out.wlast || axi_out.arvalid
		|| axi_out.rready || l2bi_stall || perf_l2_writeback))
		else
		begin
			failure_count++;
			$error("output active during reset");
		end
endmodule

bind l2_axi_bus_interface l2_axi_bus_interface_assertions protocol_checks(
	.clk(clk),
	.reset(reset),
	.axi_out(axi_out),
	.axi_in(axi_in),
	.l2bi_stall(l2bi_stall),
	.perf_l2_writeback(perf_l2_writeback),
	.writeback_queue_empty(writeback_queue_empty));

`default_nettype wire

//--- source/l2_axi_bus_interface.sv
`default_nettype none
`timescale 1ns/100ps

// Memory side of the L2 cache
// Collects misses and writebacks from l2r, runs read and write bursts on the
// AXI master port, and returns completed fills to the cache arbiter together
// with the line that was read from memory
module l2_axi_bus_interface
	#(parameter int queue_depth = 8)
	(input logic clk,
	input logic reset,

	// System memory port
	output l2_cache_pkg::axi_master_t axi_out,
	input l2_cache_pkg::axi_slave_t axi_in,

	// Toward the cache arbiter
	output l2_cache_pkg::l2req_packet_t l2bi_request,
	output l2_cache_pkg::cache_line_data_t l2bi_data_from_memory,
	output logic l2bi_stall,
	output logic l2bi_ready,
	output logic l2bi_collided_miss,

	// From the tag read stage
	input logic l2r_needs_writeback,
	input l2_cache_pkg::l2_tag_t l2r_writeback_tag,
	input l2_cache_pkg::cache_line_data_t l2r_data,
	input logic l2r_is_l2_fill,
	input logic l2r_cache_hit,
	input l2_cache_pkg::l2req_packet_t l2r_request,

	// Performance event
	output logic perf_l2_writeback);

	typedef enum logic [2:0] {
		state_idle,
		state_write_address,
		state_write_transfer,
		state_read_address,
		state_read_transfer,
		state_read_complete
	} bus_state_t;

	// One queued writeback, the evicted line and where it goes
	typedef struct packed {
		l2_cache_pkg::cache_line_index_t line_index;
		l2_cache_pkg::cache_line_data_t data;
	} writeback_entry_t;

	// One queued miss, with the collision flag captured at enqueue
	typedef struct packed {
		logic collided;
		l2_cache_pkg::l2req_packet_t request;
	} load_entry_t;

	// Stall is raised while this many slots or fewer are left
	localparam int stall_threshold = queue_depth - l2_cache_pkg::l2req_latency;

	l2_cache_pkg::cache_line_index_t miss_line;
	writeback_entry_t writeback_in;
	writeback_entry_t writeback_head;
	load_entry_t load_in;
	load_entry_t load_head;
	logic enqueue_writeback_request;
	logic enqueue_load_request;
	logic duplicate_request;
	logic writeback_queue_empty;
	logic writeback_queue_almost_full;
	logic load_queue_empty;
	logic load_queue_almost_full;
	logic writeback_complete;
	logic full_line_store;
	logic wait_axi_write_response;
	bus_state_t state_ff;
	bus_state_t state_nxt;
	l2_cache_pkg::burst_offset_t burst_offset_ff;
	l2_cache_pkg::burst_offset_t burst_offset_nxt;
	l2_cache_pkg::axi_data_t load_buffer [l2_cache_pkg::burst_beats];

	assign miss_line = '{tag: l2r_request.address.tag, set_idx: l2r_request.address.set_idx};

	// A flush that hits a dirty line, or a fill that evicts one, must write
	// the old contents back to memory first
	assign enqueue_writeback_request = l2r_request.valid && l2r_needs_writeback
		&& ((l2r_request.packet_type == l2_cache_pkg::l2req_flush && l2r_cache_hit)
		|| l2r_is_l2_fill);

	// Anything that reads or writes line data and misses needs memory
	assign enqueue_load_request = l2r_request.valid && !l2r_cache_hit && !l2r_is_l2_fill
		&& (l2r_request.packet_type == l2_cache_pkg::l2req_load
		|| l2r_request.packet_type == l2_cache_pkg::l2req_store
		|| l2r_request.packet_type == l2_cache_pkg::l2req_load_sync
		|| l2r_request.packet_type == l2_cache_pkg::l2req_store_sync);

	assign perf_l2_writeback = enqueue_writeback_request && !writeback_queue_almost_full;

	// Old tag with the set index of the request gives the evicted line
	assign writeback_in = '{
		line_index: '{tag: l2r_writeback_tag, set_idx: l2r_request.address.set_idx},
		data: l2r_data
	};

	assign load_in = '{collided: duplicate_request, request: l2r_request};

	l2_pending_miss_cam #(.num_entries(queue_depth)) pending_miss_cam(
		.clk(clk),
		.reset(reset),
		.request_valid(l2r_request.valid),
		.request_addr(miss_line),
		.enqueue_load_request(enqueue_load_request),
		.l2r_is_l2_fill(l2r_is_l2_fill),
		.duplicate_request(duplicate_request));

	sync_fifo #(
		.width($bits(writeback_entry_t)),
		.depth(queue_depth),
		.almost_full_threshold(stall_threshold)) writeback_queue(
		.clk(clk),
		.reset(reset),
		.flush_en(1'b0),
		.enqueue_en(enqueue_writeback_request),
		.value_i(writeback_in),
		.dequeue_en(writeback_complete),
		.value_o(writeback_head),
		.empty(writeback_queue_empty),
		.almost_empty(),
		.full(),
		.almost_full(writeback_queue_almost_full));

	sync_fifo #(
		.width($bits(load_entry_t)),
		.depth(queue_depth),
		.almost_full_threshold(stall_threshold)) load_queue(
		.clk(clk),
		.reset(reset),
		.flush_en(1'b0),
		.enqueue_en(enqueue_load_request),
		.value_i(load_in),
		.dequeue_en(l2bi_ready),
		.value_o(load_head),
		.empty(load_queue_empty),
		.almost_empty(),
		.full(),
		.almost_full(load_queue_almost_full));

	// The load queue head is what goes back to the arbiter
	assign l2bi_request = load_head.request;
	assign l2bi_collided_miss = load_head.collided;

	// Hold off upstream while the requests already in the pipeline could still overrun a queue
	assign l2bi_stall = load_queue_almost_full || writeback_queue_almost_full;

	// A store that overwrites every byte has no use for the old contents
	assign full_line_store = l2bi_request.packet_type == l2_cache_pkg::l2req_store
		&& l2bi_request.store_mask == '1;

	// Beat 0 of the read burst lands in the most significant word
	always_comb
	begin
		for (int k = 0; k < l2_cache_pkg::burst_beats; k++)
		begin
			l2bi_data_from_memory[(l2_cache_pkg::burst_beats - 1 - k)
				* l2_cache_pkg::axi_data_width+:l2_cache_pkg::axi_data_width] = load_buffer[k];
		end
	end

	// Bus state machine
	always_comb
	begin
		state_nxt = state_ff;
		burst_offset_nxt = burst_offset_ff;
		writeback_complete = 1'b0;
		l2bi_ready = 1'b0;

		// Addresses and write data come from the queue heads, which stay put
		// until the transaction finishes, so they are stable under back-pressure
		axi_out.awvalid = 1'b0;
		axi_out.awaddr = '{tag: writeback_head.line_index.tag,
			set_idx: writeback_head.line_index.set_idx, offset: '0};
		axi_out.wvalid = 1'b0;
		axi_out.wdata = writeback_head.data[(l2_cache_pkg::last_burst_beat - burst_offset_ff)
			* l2_cache_pkg::axi_data_width+:l2_cache_pkg::axi_data_width];
		axi_out.wlast = 1'b0;
		axi_out.arvalid = 1'b0;
		axi_out.araddr = '{tag: l2bi_request.address.tag,
			set_idx: l2bi_request.address.set_idx, offset: '0};
		axi_out.rready = 1'b0;

		unique case (state_ff)
			state_idle:
			begin
				// Writebacks go first so a later read cannot fetch stale data
				// from memory. Loads wait until the writeback queue drains
				if (!writeback_queue_empty)
				begin
					if (!wait_axi_write_response)
						state_nxt = state_write_address;
				end
				else if (!load_queue_empty)
				begin
					// Another miss already fetches this line, or the store
					// replaces all of it, so the request returns without a read
					if (l2bi_collided_miss || full_line_store)
						state_nxt = state_read_complete;
					else
						state_nxt = state_read_address;
				end
			end

			state_write_address:
			begin
				axi_out.awvalid = 1'b1;
				burst_offset_nxt = '0;
				if (axi_in.awready)
					state_nxt = state_write_transfer;
			end

			state_write_transfer:
			begin
				axi_out.wvalid = 1'b1;
				axi_out.wlast = burst_offset_ff == l2_cache_pkg::last_burst_beat;
				if (axi_in.wready)
				begin
					burst_offset_nxt = burst_offset_ff + 1'b1;
					if (burst_offset_ff == l2_cache_pkg::last_burst_beat)
					begin
						writeback_complete = 1'b1;
						state_nxt = state_idle;
					end
				end
			end

			state_read_address:
			begin
				axi_out.arvalid = 1'b1;
				burst_offset_nxt = '0;
				if (axi_in.arready)
					state_nxt = state_read_transfer;
			end

			state_read_transfer:
			begin
				axi_out.rready = 1'b1;
				if (axi_in.rvalid)
				begin
					burst_offset_nxt = burst_offset_ff + 1'b1;
					if (burst_offset_ff == l2_cache_pkg::last_burst_beat)
						state_nxt = state_read_complete;
				end
			end

			state_read_complete:
			begin
				// The arbiter always takes the returned request
				l2bi_ready = 1'b1;
				state_nxt = state_idle;
			end

			default:
				state_nxt = state_idle;
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state_ff <= state_idle;
			burst_offset_ff <= '0;
			wait_axi_write_response <= 1'b0;
		end
		else
		begin
			state_ff <= state_nxt;
			burst_offset_ff <= burst_offset_nxt;

			// One write response is expected per burst, and the next burst
			// waits for it
			if (axi_out.awvalid && axi_in.awready)
				wait_axi_write_response <= 1'b1;
			else if (axi_in.bvalid)
				wait_axi_write_response <= 1'b0;
		end
	end

	// Capture each read beat at its position in the burst
	always_ff @(posedge clk)
	begin
		if (state_ff == state_read_transfer && axi_in.rvalid)
			load_buffer[burst_offset_ff] <= axi_in.rdata;
	end
endmodule

`default_nettype wire

//--- source/l2_pending_miss_cam.sv
`default_nettype none
`timescale 1ns/100ps

// Table of cache lines that already have a memory read in flight
// A miss to a line that is already in this table is flagged as a duplicate,
// so the bus interface can hand it back without issuing another read
module l2_pending_miss_cam
	#(parameter int num_entries = 8)
	(input logic clk,
	input logic reset,
	input logic request_valid,
	input l2_cache_pkg::cache_line_index_t request_addr,
	input logic enqueue_load_request,
	input logic l2r_is_l2_fill,
	output logic duplicate_request);

	localparam int index_width = (num_entries > 1) ? $clog2(num_entries) : 1;

	logic [num_entries - 1:0] entry_valid;
	l2_cache_pkg::cache_line_index_t entry_addr [num_entries];
	logic [num_entries - 1:0] match;
	logic free_found;
	logic [index_width - 1:0] free_index;
	logic allocate;

	// Compare the incoming line against every entry at once
	always_comb
	begin
		for (int i = 0; i < num_entries; i++)
			match[i] = entry_valid[i] && entry_addr[i] == request_addr;
	end

	assign duplicate_request = request_valid && |match;

	// Pick the lowest numbered free slot
	// The loop runs downward so the last assignment wins for the lowest index
	always_comb
	begin
		free_found = 1'b0;
		free_index = '0;
		for (int i = num_entries - 1; i >= 0; i--)
		begin
			if (!entry_valid[i])
			begin
				free_found = 1'b1;
				free_index = index_width'(i);
			end
		end
	end

	// A first miss to a line takes a slot
	// The load queue is never deeper than this table, so a slot is always free
	assign allocate = enqueue_load_request && !duplicate_request && free_found;

	always_ff @(posedge clk)
	begin
		if (allocate)
			entry_addr[free_index] <= request_addr;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			entry_valid <= '0;
		else
		begin
			// When the fill for a line comes back through l2r the line is
			// resident again, and later misses to it must read memory anew
			if (request_valid && l2r_is_l2_fill)
				entry_valid <= entry_valid & ~match;

			// Fill and enqueue never occur together, because an enqueued
			// load miss is by definition not a fill
			if (allocate)
				entry_valid[free_index] <= 1'b1;
		end
	end
endmodule

`default_nettype wire

//--- source/sync_fifo.sv
`default_nettype none
`timescale 1ns/100ps

// Circular buffer with a fall-through head
// The head entry is visible on value_o whenever empty is low, so a consumer
// can look at it and decide to dequeue in the same cycle
module sync_fifo
	#(parameter int width = 64,
	parameter int depth = 8,
	parameter int almost_full_threshold = depth)
	(input logic clk,
	input logic reset,
	input logic flush_en,
	input logic enqueue_en,
	input logic [width - 1:0] value_i,
	input logic dequeue_en,
	output logic [width - 1:0] value_o,
	output logic empty,
	output logic almost_empty,
	output logic full,
	output logic almost_full);

	localparam int addr_width = (depth > 1) ? $clog2(depth) : 1;
	localparam int count_width = $clog2(depth + 1);

	logic [width - 1:0] storage [depth];
	logic [addr_width - 1:0] read_ptr;
	logic [addr_width - 1:0] write_ptr;
	logic [count_width - 1:0] count;
	logic do_enqueue;
	logic do_dequeue;

	// Writes to a full queue and reads from an empty one are dropped
	assign do_enqueue = enqueue_en && !full;
	assign do_dequeue = dequeue_en && !empty;

	assign value_o = storage[read_ptr];

	// All status flags come straight from the entry count
	assign empty = count == '0;
	assign almost_empty = count <= count_width'(1);
	assign full = count == count_width'(depth);
	assign almost_full = count >= count_width'(almost_full_threshold);

	always_ff @(posedge clk)
	begin
		if (do_enqueue)
			storage[write_ptr] <= value_i;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			read_ptr <= '0;
			write_ptr <= '0;
			count <= '0;
		end
		else if (flush_en)
		begin
			// Flush drops every entry but leaves the storage untouched
			read_ptr <= '0;
			write_ptr <= '0;
			count <= '0;
		end
		else
		begin
			// Pointers wrap by hand so that depth need not be a power of two
			if (do_enqueue)
			begin
				if (write_ptr == addr_width'(depth - 1))
					write_ptr <= '0;
				else
					write_ptr <= write_ptr + 1'b1;
			end

			if (do_dequeue)
			begin
				if (read_ptr == addr_width'(depth - 1))
					read_ptr <= '0;
				else
					read_ptr <= read_ptr + 1'b1;
			end

			// Simultaneous push and pop leave the count unchanged
			case ({do_enqueue, do_dequeue})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end
endmodule

`default_nettype wire

//--- source/l2_cache_pkg.sv
`default_nettype none

// Shared geometry, bus and request definitions for the L2 cache memory interface
package l2_cache_pkg;
	// Cache line geometry
	localparam int cache_line_bits = 128;
	localparam int cache_line_bytes = cache_line_bits / 8;
	localparam int cache_line_offset_width = $clog2(cache_line_bytes);
	localparam int set_index_width = 6;
	localparam int tag_width = 32 - set_index_width - cache_line_offset_width;

	// Memory bus geometry, a line moves as one fixed-length burst
	localparam int axi_data_width = 32;
	localparam int burst_beats = cache_line_bits / axi_data_width;

	// Stages ahead of l2r; stall must be raised this many entries early
	// so that requests already in flight upstream still fit in the queues
	localparam int l2req_latency = 4;

	typedef logic [tag_width - 1:0] l2_tag_t;
	typedef logic [set_index_width - 1:0] set_index_t;
	typedef logic [cache_line_bits - 1:0] cache_line_data_t;
	typedef logic [axi_data_width - 1:0] axi_data_t;
	typedef logic [cache_line_bytes - 1:0] store_mask_t;

	// Beat number within a burst
	typedef logic [$clog2(burst_beats) - 1:0] burst_offset_t;

	localparam burst_offset_t last_burst_beat = burst_offset_t'(burst_beats - 1);

	// Address of a whole line, without the byte offset
	typedef struct packed {
		l2_tag_t tag;
		set_index_t set_idx;
	} cache_line_index_t;

	// Full byte address
	typedef struct packed {
		l2_tag_t tag;
		set_index_t set_idx;
		logic [cache_line_offset_width - 1:0] offset;
	} l2_addr_t;

	typedef enum logic [2:0] {
		l2req_load,
		l2req_store,
		l2req_flush,
		l2req_load_sync,
		l2req_store_sync
	} l2req_type_t;

	typedef struct packed {
		logic valid;
		l2req_type_t packet_type;
		l2_addr_t address;
		store_mask_t store_mask;
		cache_line_data_t data;
	} l2req_packet_t;

	// Signals driven by the bus master toward memory
	typedef struct packed {
		logic awvalid;
		l2_addr_t awaddr;
		logic wvalid;
		axi_data_t wdata;
		logic wlast;
		logic arvalid;
		l2_addr_t araddr;
		logic rready;
	} axi_master_t;

	// Signals driven by memory back toward the master
	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic arready;
		logic rvalid;
		axi_data_t rdata;
	} axi_slave_t;
endpackage

`default_nettype wire
